/* logic/cpu_cfg_pkg.sv */
/*
 * core configuration defaults, overridable per instance from the top level
 * instruction RAM is word addressed, PC values carry bits 31:2 only
 */
package cpu_cfg_pkg;

	// instruction RAM word-address width, 1024 words by default
	localparam int IWIDTH_DEFAULT = 10;

	localparam logic [31:2] RESET_PC = 30'd0; // held while idle

endpackage

/* logic/rv32i_isa_pkg.sv */
/*
 * RV32I subset encodings and the decode/forwarding types of the core
 * only ALU, lui, branch and jal classes are covered
 */
package rv32i_isa_pkg;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

	localparam logic [31:0] NOP_INST = 32'h0000_0013; // addi x0,x0,0

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_t;

	typedef logic [4:0] reg_idx_t;

	// operand source seen by execute
	typedef enum logic [1:0] {
		FWD_RF = 2'd0,
		FWD_EX = 2'd1,
		FWD_WB = 2'd2
	} fwd_sel_t;

endpackage

/* logic/cpu_status.sv */
/*
 * run/idle control: start pulse latches the address, quit returns to idle
 * start while running and quit while idle are ignored
 */
module cpu_status (
	input  logic        clk,
	input  logic        i_reset,
	input  logic        i_cpu_start,
	input  logic        i_quit_cmd,
	input  logic [31:2] i_start_adr,
	output logic        o_cpu_run_state,
	output logic        o_pc_start,
	output logic [31:2] o_start_adr_lat,
	output logic        o_rst_pipe
);

	logic start_ok;
	logic quit_ok;

	assign start_ok = i_cpu_start & ~o_cpu_run_state;
	assign quit_ok = i_quit_cmd & o_cpu_run_state;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_cpu_run_state <= 1'b0;
			o_pc_start <= 1'b0;
			o_rst_pipe <= 1'b0;
		end else begin
			o_pc_start <= start_ok; // same cycle as run rising
			o_rst_pipe <= quit_ok;  // same cycle as run falling
			if (start_ok)
				o_cpu_run_state <= 1'b1;
			else if (quit_ok)
				o_cpu_run_state <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok)
			o_start_adr_lat <= i_start_adr;
	end

endmodule

/* logic/if_stage.sv */
/*
 * fetch with a local instruction RAM, synchronous read, no refill path
 * host writes are accepted any time but should only happen while idle
 */
module if_stage
	import cpu_cfg_pkg::*, rv32i_isa_pkg::*;
	#(parameter int IWIDTH = IWIDTH_DEFAULT)
	(
	input  logic              clk,
	input  logic              i_reset,
	input  logic              i_run,
	input  logic              i_pc_start,
	input  logic [31:2]       i_start_adr_lat,
	input  logic              i_jmp_condition_ex,
	input  logic [31:2]       i_jmp_adr_ex,
	input  logic              i_iram_wen,
	input  logic [IWIDTH-1:0] i_iram_wadr,
	input  logic [31:0]       i_iram_wdata,
	output logic [31:0]       o_inst_id,
	output logic [31:2]       o_pc_id
);

	logic [31:0] iram [1 << IWIDTH];
	logic [31:0] iram_q;
	logic [31:2] pc_if;
	logic fetch_vld;

	always_ff @(posedge clk) begin
		if (i_reset)
			pc_if <= RESET_PC;
		else if (i_pc_start)
			pc_if <= i_start_adr_lat;
		else if (!i_run)
			pc_if <= RESET_PC;
		else if (i_jmp_condition_ex)
			pc_if <= i_jmp_adr_ex; // redirect from execute
		else
			pc_if <= pc_if + 30'd1;
	end

	always_ff @(posedge clk) begin
		if (i_iram_wen)
			iram[i_iram_wadr] <= i_iram_wdata;
		iram_q <= iram[pc_if[IWIDTH+1:2]];
		o_pc_id <= pc_if;
	end

	// word read while idle or during the start cycle is not a real fetch
	always_ff @(posedge clk) begin
		if (i_reset)
			fetch_vld <= 1'b0;
		else
			fetch_vld <= i_run & ~i_pc_start;
	end

	assign o_inst_id = fetch_vld ? iram_q : NOP_INST;

endmodule

/* logic/id_stage.sv */
/*
 * decode and register file; unknown encodings decode as no-ops
 * the two slots behind a taken jump enter execute invalid
 */
module id_stage import rv32i_isa_pkg::*; (
	input  logic        clk,
	input  logic        i_reset,
	input  logic        i_rst_pipe,
	input  logic [31:0] i_inst_id,
	input  logic [31:2] i_pc_id,
	input  logic        i_jmp_condition_ex,
	input  logic        i_wbk_we_wb,
	input  reg_idx_t    i_wbk_adr_wb,
	input  logic [31:0] i_wbk_data_wb,
	input  reg_idx_t    i_rf_radr_mon,
	output reg_idx_t    o_rs1_id,
	output reg_idx_t    o_rs2_id,
	output logic        o_valid_ex,
	output alu_op_t     o_alu_op_ex,
	output logic        o_op2_imm_ex,
	output logic [31:0] o_imm_ex,
	output logic [31:0] o_rs1_data_ex,
	output logic [31:0] o_rs2_data_ex,
	output logic [31:2] o_pc_ex,
	output logic        o_cmd_br_ex,
	output logic        o_cmd_jal_ex,
	output logic [2:0]  o_br_code_ex,
	output reg_idx_t    o_rd_adr_ex,
	output logic        o_wbk_rd_reg_ex,
	output logic [31:0] o_rf_rdata_mon
);

	logic [31:0] rf [32];
	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	reg_idx_t rd;
	logic is_op, is_opimm, is_lui, is_br, is_jal;
	logic op_ok, opimm_ok, br_ok;
	logic dec_wr;
	alu_op_t alu_op;
	logic [31:0] imm;
	logic jmp_purge_ex;
	logic squash;

	assign opcode = i_inst_id[6:0];
	assign funct3 = i_inst_id[14:12];
	assign funct7 = i_inst_id[31:25];
	assign rd = i_inst_id[11:7];

	assign is_op = (opcode == OPC_OP);
	assign is_opimm = (opcode == OPC_OPIMM);
	assign is_lui = (opcode == OPC_LUI);
	assign is_br = (opcode == OPC_BRANCH);
	assign is_jal = (opcode == OPC_JAL);

	assign op_ok = is_op & ((funct7 == F7_BASE) |
		((funct7 == F7_ALT) & ((funct3 == F3_ADD_SUB) | (funct3 == F3_SRL_SRA))));
	assign opimm_ok = is_opimm & ((funct3 != F3_SLL) | (funct7 == F7_BASE)) &
		((funct3 != F3_SRL_SRA) | (funct7 == F7_BASE) | (funct7 == F7_ALT));
	assign br_ok = is_br & (funct3[2:1] != 2'b01);
	assign dec_wr = (op_ok | opimm_ok | is_lui | is_jal) & (rd != '0);

	// lui and jal have no rs1, index 0 keeps forwarding out
	assign o_rs1_id = (is_lui | is_jal) ? '0 : i_inst_id[19:15];
	assign o_rs2_id = i_inst_id[24:20];

	always_comb begin
		alu_op = ALU_ADD; // lui and jal link use the adder
		if (is_op | is_opimm) begin
			case (funct3)
				F3_ADD_SUB: alu_op = (is_op && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
				F3_SLL:     alu_op = ALU_SLL;
				F3_SLT:     alu_op = ALU_SLT;
				F3_SLTU:    alu_op = ALU_SLTU;
				F3_XOR:     alu_op = ALU_XOR;
				F3_SRL_SRA: alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
				F3_OR:      alu_op = ALU_OR;
				default:    alu_op = ALU_AND;
			endcase
		end
	end

	always_comb begin
		case (opcode)
			OPC_LUI: imm = {i_inst_id[31:12], 12'd0};
			OPC_BRANCH: imm = {{20{i_inst_id[31]}}, i_inst_id[7], i_inst_id[30:25],
				i_inst_id[11:8], 1'b0};
			OPC_JAL: imm = {{12{i_inst_id[31]}}, i_inst_id[19:12], i_inst_id[20],
				i_inst_id[30:21], 1'b0};
			default: imm = {{20{i_inst_id[31]}}, i_inst_id[31:20]};
		endcase
	end

	// registers start at zero, x0 is never written
	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++)
				rf[i] <= 32'd0;
		end else if (i_wbk_we_wb && i_wbk_adr_wb != '0) begin
			rf[i_wbk_adr_wb] <= i_wbk_data_wb;
		end
	end

	assign squash = i_rst_pipe | i_jmp_condition_ex | jmp_purge_ex;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_valid_ex <= 1'b0;
			jmp_purge_ex <= 1'b0;
			o_cmd_br_ex <= 1'b0;
			o_cmd_jal_ex <= 1'b0;
			o_wbk_rd_reg_ex <= 1'b0;
		end else begin
			o_valid_ex <= ~squash;
			jmp_purge_ex <= i_jmp_condition_ex; // marks the second slot
			o_cmd_br_ex <= br_ok;
			o_cmd_jal_ex <= is_jal;
			o_wbk_rd_reg_ex <= dec_wr & ~squash;
		end
	end

	always_ff @(posedge clk) begin
		o_alu_op_ex <= alu_op;
		o_op2_imm_ex <= is_opimm | is_lui;
		o_imm_ex <= imm;
		o_rs1_data_ex <= rf[o_rs1_id];
		o_rs2_data_ex <= rf[o_rs2_id];
		o_pc_ex <= i_pc_id;
		o_br_code_ex <= funct3;
		o_rd_adr_ex <= rd;
		o_rf_rdata_mon <= rf[i_rf_radr_mon];
	end

endmodule

/* logic/forwarding.sv */
/*
 * operand source select for the instruction entering execute
 * execute and writeback are the only producers, no load hazards exist
 */
module forwarding import rv32i_isa_pkg::*; (
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_rst_pipe,
	input  reg_idx_t i_rs1_id,
	input  reg_idx_t i_rs2_id,
	input  reg_idx_t i_rd_adr_ex,
	input  logic     i_wbk_rd_reg_ex,
	input  reg_idx_t i_wbk_adr_wb,
	input  logic     i_wbk_we_wb,
	input  logic     i_jmp_condition_ex,
	output fwd_sel_t o_fwd_rs1_ex,
	output fwd_sel_t o_fwd_rs2_ex
);

	// nearer producer first, purged slots never have wbk_rd_reg_ex set
	function automatic fwd_sel_t pick(input reg_idx_t rs);
		if (rs == '0)
			return FWD_RF;
		else if (i_wbk_rd_reg_ex && rs == i_rd_adr_ex)
			return FWD_EX;
		else if (i_wbk_we_wb && rs == i_wbk_adr_wb)
			return FWD_WB;
		else
			return FWD_RF;
	endfunction

	always_ff @(posedge clk) begin
		if (i_reset || i_rst_pipe || i_jmp_condition_ex) begin
			o_fwd_rs1_ex <= FWD_RF; // slot is squashed
			o_fwd_rs2_ex <= FWD_RF;
		end else begin
			o_fwd_rs1_ex <= pick(i_rs1_id);
			o_fwd_rs2_ex <= pick(i_rs2_id);
		end
	end

endmodule

/* logic/ex_stage.sv */
/*
 * ALU, branch/jal resolution and the writeback register
 * jump target is pc-relative only; offset bits below 2 are ignored
 */
module ex_stage import rv32i_isa_pkg::*; (
	input  logic        clk,
	input  logic        i_reset,
	input  logic        i_rst_pipe,
	input  logic        i_valid_ex,
	input  alu_op_t     i_alu_op_ex,
	input  logic        i_op2_imm_ex,
	input  logic [31:0] i_imm_ex,
	input  logic [31:0] i_rs1_data_ex,
	input  logic [31:0] i_rs2_data_ex,
	input  logic [31:2] i_pc_ex,
	input  logic        i_cmd_br_ex,
	input  logic        i_cmd_jal_ex,
	input  logic [2:0]  i_br_code_ex,
	input  reg_idx_t    i_rd_adr_ex,
	input  logic        i_wbk_rd_reg_ex,
	input  fwd_sel_t    i_fwd_rs1_ex,
	input  fwd_sel_t    i_fwd_rs2_ex,
	output logic        o_jmp_condition_ex,
	output logic [31:2] o_jmp_adr_ex,
	output logic        o_wbk_we_wb,
	output reg_idx_t    o_wbk_adr_wb,
	output logic [31:0] o_wbk_data_wb,
	output logic [31:0] o_pc_data
);

	logic [31:0] wbk_data_prev; // value written to the RF last cycle
	logic [31:0] rs1_val, rs2_val;
	logic [31:0] op1, op2;
	logic [31:0] alu_res;
	logic br_taken;

	function automatic logic [31:0] fwd_mux(input fwd_sel_t sel, input logic [31:0] rf_val,
		input logic [31:0] ex_val, input logic [31:0] wb_val);
		case (sel)
			FWD_EX:  return ex_val;
			FWD_WB:  return wb_val;
			default: return rf_val;
		endcase
	endfunction

	assign rs1_val = fwd_mux(i_fwd_rs1_ex, i_rs1_data_ex, o_wbk_data_wb, wbk_data_prev);
	assign rs2_val = fwd_mux(i_fwd_rs2_ex, i_rs2_data_ex, o_wbk_data_wb, wbk_data_prev);

	assign op1 = i_cmd_jal_ex ? {i_pc_ex, 2'b00} : rs1_val;
	assign op2 = i_cmd_jal_ex ? 32'd4 : (i_op2_imm_ex ? i_imm_ex : rs2_val); // link = pc+4

	always_comb begin
		case (i_alu_op_ex)
			ALU_SUB:  alu_res = op1 - op2;
			ALU_AND:  alu_res = op1 & op2;
			ALU_OR:   alu_res = op1 | op2;
			ALU_XOR:  alu_res = op1 ^ op2;
			ALU_SLT:  alu_res = {31'd0, $signed(op1) < $signed(op2)};
			ALU_SLTU: alu_res = {31'd0, op1 < op2};
			ALU_SLL:  alu_res = op1 << op2[4:0];
			ALU_SRL:  alu_res = op1 >> op2[4:0];
			ALU_SRA:  alu_res = $signed(op1) >>> op2[4:0];
			default:  alu_res = op1 + op2;
		endcase
	end

	always_comb begin
		case (i_br_code_ex)
			F3_BEQ:  br_taken = (rs1_val == rs2_val);
			F3_BNE:  br_taken = (rs1_val != rs2_val);
			F3_BLT:  br_taken = ($signed(rs1_val) < $signed(rs2_val));
			F3_BGE:  br_taken = ($signed(rs1_val) >= $signed(rs2_val));
			F3_BLTU: br_taken = (rs1_val < rs2_val);
			F3_BGEU: br_taken = (rs1_val >= rs2_val);
			default: br_taken = 1'b0;
		endcase
	end

	assign o_jmp_condition_ex = i_valid_ex & (i_cmd_jal_ex | (i_cmd_br_ex & br_taken));
	assign o_jmp_adr_ex = i_pc_ex + i_imm_ex[31:2];

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_wbk_we_wb <= 1'b0;
			o_pc_data <= 32'd0;
		end else begin
			o_wbk_we_wb <= i_valid_ex & i_wbk_rd_reg_ex & ~i_rst_pipe;
			if (i_valid_ex)
				o_pc_data <= {i_pc_ex, 2'b00};
		end
	end

	always_ff @(posedge clk) begin
		o_wbk_adr_wb <= i_rd_adr_ex;
		o_wbk_data_wb <= alu_res;
		wbk_data_prev <= o_wbk_data_wb;
	end

endmodule

/* logic/cpu_top.sv */
/*
 * four-stage RV32I subset core: no loads/stores, CSRs or traps
 * programs are loaded through the instruction RAM port while idle
 */
module cpu_top
	import cpu_cfg_pkg::*, rv32i_isa_pkg::*;
	#(parameter int IWIDTH = IWIDTH_DEFAULT)
	(
	input  logic              clk,
	input  logic              i_reset,
	input  logic              i_cpu_start,
	input  logic              i_quit_cmd,
	input  logic [31:2]       i_start_adr,
	input  logic              i_iram_wen,
	input  logic [IWIDTH-1:0] i_iram_wadr,
	input  logic [31:0]       i_iram_wdata,
	input  reg_idx_t          i_rf_radr_mon,
	output logic              o_cpu_run_state,
	output logic [31:0]       o_pc_data,
	output logic [31:0]       o_rf_rdata_mon
);

	logic pc_start, rst_pipe;
	logic [31:2] start_adr_lat, pc_id, pc_ex, jmp_adr_ex;
	logic [31:0] inst_id, imm_ex, rs1_data_ex, rs2_data_ex, wbk_data_wb;
	logic jmp_condition_ex, valid_ex, op2_imm_ex, cmd_br_ex, cmd_jal_ex;
	logic wbk_rd_reg_ex, wbk_we_wb;
	logic [2:0] br_code_ex;
	reg_idx_t rs1_id, rs2_id, rd_adr_ex, wbk_adr_wb;
	alu_op_t alu_op_ex;
	fwd_sel_t fwd_rs1_ex, fwd_rs2_ex;

	cpu_status cpu_status (
		.clk(clk), .i_reset(i_reset),
		.i_cpu_start(i_cpu_start), .i_quit_cmd(i_quit_cmd), .i_start_adr(i_start_adr),
		.o_cpu_run_state(o_cpu_run_state), .o_pc_start(pc_start),
		.o_start_adr_lat(start_adr_lat), .o_rst_pipe(rst_pipe)
	);

	if_stage #(.IWIDTH(IWIDTH)) if_stage (
		.clk(clk), .i_reset(i_reset),
		.i_run(o_cpu_run_state), .i_pc_start(pc_start), .i_start_adr_lat(start_adr_lat),
		.i_jmp_condition_ex(jmp_condition_ex), .i_jmp_adr_ex(jmp_adr_ex),
		.i_iram_wen(i_iram_wen), .i_iram_wadr(i_iram_wadr), .i_iram_wdata(i_iram_wdata),
		.o_inst_id(inst_id), .o_pc_id(pc_id)
	);

	id_stage id_stage (
		.clk(clk), .i_reset(i_reset), .i_rst_pipe(rst_pipe),
		.i_inst_id(inst_id), .i_pc_id(pc_id), .i_jmp_condition_ex(jmp_condition_ex),
		.i_wbk_we_wb(wbk_we_wb), .i_wbk_adr_wb(wbk_adr_wb), .i_wbk_data_wb(wbk_data_wb),
		.i_rf_radr_mon(i_rf_radr_mon),
		.o_rs1_id(rs1_id), .o_rs2_id(rs2_id), .o_valid_ex(valid_ex),
		.o_alu_op_ex(alu_op_ex), .o_op2_imm_ex(op2_imm_ex), .o_imm_ex(imm_ex),
		.o_rs1_data_ex(rs1_data_ex), .o_rs2_data_ex(rs2_data_ex), .o_pc_ex(pc_ex),
		.o_cmd_br_ex(cmd_br_ex), .o_cmd_jal_ex(cmd_jal_ex), .o_br_code_ex(br_code_ex),
		.o_rd_adr_ex(rd_adr_ex), .o_wbk_rd_reg_ex(wbk_rd_reg_ex),
		.o_rf_rdata_mon(o_rf_rdata_mon)
	);

	forwarding forwarding (
		.clk(clk), .i_reset(i_reset), .i_rst_pipe(rst_pipe),
		.i_rs1_id(rs1_id), .i_rs2_id(rs2_id),
		.i_rd_adr_ex(rd_adr_ex), .i_wbk_rd_reg_ex(wbk_rd_reg_ex),
		.i_wbk_adr_wb(wbk_adr_wb), .i_wbk_we_wb(wbk_we_wb),
		.i_jmp_condition_ex(jmp_condition_ex),
		.o_fwd_rs1_ex(fwd_rs1_ex), .o_fwd_rs2_ex(fwd_rs2_ex)
	);

	ex_stage ex_stage (
		.clk(clk), .i_reset(i_reset), .i_rst_pipe(rst_pipe),
		.i_valid_ex(valid_ex), .i_alu_op_ex(alu_op_ex),
		.i_op2_imm_ex(op2_imm_ex), .i_imm_ex(imm_ex),
		.i_rs1_data_ex(rs1_data_ex), .i_rs2_data_ex(rs2_data_ex), .i_pc_ex(pc_ex),
		.i_cmd_br_ex(cmd_br_ex), .i_cmd_jal_ex(cmd_jal_ex), .i_br_code_ex(br_code_ex),
		.i_rd_adr_ex(rd_adr_ex), .i_wbk_rd_reg_ex(wbk_rd_reg_ex),
		.i_fwd_rs1_ex(fwd_rs1_ex), .i_fwd_rs2_ex(fwd_rs2_ex),
		.o_jmp_condition_ex(jmp_condition_ex), .o_jmp_adr_ex(jmp_adr_ex),
		.o_wbk_we_wb(wbk_we_wb), .o_wbk_adr_wb(wbk_adr_wb), .o_wbk_data_wb(wbk_data_wb),
		.o_pc_data(o_pc_data)
	);

endmodule

/* test/cpu_top_assert.sv */
/*
 * run-control properties for the core top level, attached with bind
 * the unknown-bit check on o_pc_data only fires on four-state simulators
 */
module cpu_top_assert (
	input logic        clk,
	input logic        i_reset,
	input logic        i_cpu_start,
	input logic        i_quit_cmd,
	input logic        i_run_state,
	input logic [31:0] i_pc_data
);

	a_run_rise: assert property (@(posedge clk) disable iff (i_reset)
		$rose(i_run_state) |-> $past(i_cpu_start))
		else $error("run state rose without a start pulse");

	a_start_taken: assert property (@(posedge clk) disable iff (i_reset)
		(i_cpu_start && !i_run_state) |=> i_run_state)
		else $error("start pulse while idle did not start the core");

	a_run_fall: assert property (@(posedge clk) disable iff (i_reset)
		$fell(i_run_state) |-> $past(i_quit_cmd))
		else $error("run state fell without a quit command");

	a_quit_taken: assert property (@(posedge clk) disable iff (i_reset)
		(i_quit_cmd && i_run_state) |=> !i_run_state)
		else $error("quit command while running did not stop the core");

	// pc monitor must be defined once the core runs
	a_pc_known: assert property (@(posedge clk) disable iff (i_reset)
		i_run_state |-> !$isunknown(i_pc_data))
		else $error("o_pc_data has unknown bits while running");

endmodule

/* test/tb_cpu_top.sv */
/*
 * random RV32I programs (x0..x7, forward branches only) against an ISA model
 * register file persists across programs, only the first reset clears it
 */
module tb_cpu_top import cpu_cfg_pkg::*, rv32i_isa_pkg::*;;

	localparam int IWIDTH = IWIDTH_DEFAULT;
	localparam int unsigned LOOP_IDX = 40; // final jal x0,0 sits here
	localparam int unsigned NPROG = 10;
	localparam int unsigned RUN_CYCLES = 200;
	localparam int unsigned MAX_START = (1 << IWIDTH) - 48;

	logic clk;
	logic i_reset, i_cpu_start, i_quit_cmd;
	logic [31:2] i_start_adr;
	logic i_iram_wen;
	logic [IWIDTH-1:0] i_iram_wadr;
	logic [31:0] i_iram_wdata;
	reg_idx_t i_rf_radr_mon;
	logic o_cpu_run_state;
	logic [31:0] o_pc_data, o_rf_rdata_mon;

	int seed;
	logic [31:0] prog [LOOP_IDX + 1];
	logic [31:0] mrf [32]; // model register file

	cpu_top #(.IWIDTH(IWIDTH)) i_cpu_top (
		.clk(clk), .i_reset(i_reset),
		.i_cpu_start(i_cpu_start), .i_quit_cmd(i_quit_cmd), .i_start_adr(i_start_adr),
		.i_iram_wen(i_iram_wen), .i_iram_wadr(i_iram_wadr), .i_iram_wdata(i_iram_wdata),
		.i_rf_radr_mon(i_rf_radr_mon),
		.o_cpu_run_state(o_cpu_run_state), .o_pc_data(o_pc_data),
		.o_rf_rdata_mon(o_rf_rdata_mon)
	);

	bind cpu_top cpu_top_assert i_run_checks (
		.clk(clk), .i_reset(i_reset), .i_cpu_start(i_cpu_start), .i_quit_cmd(i_quit_cmd),
		.i_run_state(o_cpu_run_state), .i_pc_data(o_pc_data)
	);

	always #2 clk = ~clk;

	function automatic int unsigned urand(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] enc_branch(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  return (a < b) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic gen_program();
		int unsigned kind, off, lim, pick;
		logic [4:0] rd, rs1, rs2;
		logic [2:0] f3;
		logic alt;
		logic [11:0] imm12;
		logic [31:0] r32;
		for (int unsigned i = 0; i < LOOP_IDX; i++) begin
			kind = urand(10);
			rd = 5'(urand(8));
			rs1 = 5'(urand(8));
			rs2 = 5'(urand(8));
			f3 = 3'(urand(8));
			alt = 1'(urand(2));
			lim = (LOOP_IDX - i < 8) ? LOOP_IDX - i : 8;
			off = 1 + urand(lim); // forward only, never past the final loop
			if (kind < 4) begin
				alt = alt & (f3 == 3'b000 || f3 == 3'b101);
				prog[i] = {alt ? F7_ALT : F7_BASE, rs2, rs1, f3, rd, OPC_OP};
			end else if (kind < 7) begin
				imm12 = 12'(urand(4096));
				if (f3 == 3'b001)
					imm12 = {F7_BASE, rs2}; // shamt
				else if (f3 == 3'b101)
					imm12 = {alt ? F7_ALT : F7_BASE, rs2};
				prog[i] = {imm12, rs1, f3, rd, OPC_OPIMM};
			end else if (kind == 7) begin
				r32 = $random(seed);
				prog[i] = {r32[31:12], rd, OPC_LUI};
			end else if (kind == 8) begin
				pick = urand(6);
				f3 = (pick < 2) ? 3'(pick) : 3'(pick + 2);
				prog[i] = enc_branch(13'(off * 4), rs2, rs1, f3);
			end else begin
				prog[i] = enc_jal(21'(off * 4), rd);
			end
		end
		prog[LOOP_IDX] = enc_jal(21'd0, 5'd0);
	endtask

	// interprets the program words from its first slot until the self-loop
	task automatic run_model(input int unsigned start);
		int unsigned idx, nxt;
		logic [31:0] w, a, b, res, bimm, jimm;
		logic wr;
		idx = 0;
		while (idx < LOOP_IDX) begin
			w = prog[idx];
			a = mrf[w[19:15]];
			b = mrf[w[24:20]];
			nxt = idx + 1;
			wr = 1'b0;
			res = 32'd0;
			bimm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			jimm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			case (w[6:0])
				OPC_OP: begin
					wr = 1'b1;
					res = alu_ref(w[14:12], w[30], a, b);
				end
				OPC_OPIMM: begin
					wr = 1'b1;
					res = alu_ref(w[14:12], (w[14:12] == 3'b101) && w[30], a,
						{{20{w[31]}}, w[31:20]});
				end
				OPC_LUI: begin
					wr = 1'b1;
					res = {w[31:12], 12'd0};
				end
				OPC_BRANCH: if (taken_ref(w[14:12], a, b)) nxt = idx + (bimm >> 2);
				OPC_JAL: begin
					wr = 1'b1;
					res = (start + idx) * 4 + 4; // link is the byte address after jal
					nxt = idx + (jimm >> 2);
				end
				default: ;
			endcase
			if (wr && w[11:7] != 5'd0)
				mrf[w[11:7]] = res;
			idx = nxt;
		end
	endtask

	task automatic load_program(input int unsigned start);
		for (int unsigned i = 0; i <= LOOP_IDX; i++) begin
			@(posedge clk);
			i_iram_wen <= 1'b1;
			i_iram_wadr <= IWIDTH'(start + i);
			i_iram_wdata <= prog[i];
		end
		@(posedge clk);
		i_iram_wen <= 1'b0;
	endtask

	task automatic start_core(input int unsigned start);
		@(posedge clk);
		i_cpu_start <= 1'b1;
		i_start_adr <= 30'(start);
		@(negedge clk);
		check_eq("o_cpu_run_state before start", 32'(o_cpu_run_state), 32'd0);
		@(posedge clk);
		i_cpu_start <= 1'b0;
		@(negedge clk);
		check_eq("o_cpu_run_state after start", 32'(o_cpu_run_state), 32'd1);
	endtask

	task automatic quit_core();
		@(posedge clk);
		i_quit_cmd <= 1'b1;
		@(negedge clk);
		check_eq("o_cpu_run_state before quit", 32'(o_cpu_run_state), 32'd1);
		@(posedge clk);
		i_quit_cmd <= 1'b0;
		@(negedge clk);
		check_eq("o_cpu_run_state after quit", 32'(o_cpu_run_state), 32'd0);
	endtask

	task automatic check_registers();
		for (int unsigned r = 0; r < 8; r++) begin
			@(posedge clk);
			i_rf_radr_mon <= 5'(r);
			@(posedge clk); // monitor read is registered
			@(negedge clk);
			check_eq($sformatf("o_rf_rdata_mon x%0d", r), o_rf_rdata_mon, mrf[r]);
		end
	endtask

	initial begin
		#((NPROG * 300 + 8) * 4);
		$display("watchdog expired before all programs completed");
		$display("Test failures found");
		$fatal(1, "timeout");
	end

	initial begin
		int unsigned start, prev;
		seed = 10;
		clk = 1'b0;
		i_reset = 1'b1;
		i_cpu_start = 1'b0;
		i_quit_cmd = 1'b0;
		i_start_adr = '0;
		i_iram_wen = 1'b0;
		i_iram_wadr = '0;
		i_iram_wdata = '0;
		i_rf_radr_mon = '0;
		for (int i = 0; i < 32; i++)
			mrf[i] = 32'd0;
		prev = MAX_START;
		repeat (8) @(posedge clk);
		i_reset <= 1'b0;
		@(negedge clk);
		check_eq("o_cpu_run_state after reset", 32'(o_cpu_run_state), 32'd0);
		for (int unsigned p = 0; p < NPROG; p++) begin
			gen_program();
			start = urand(MAX_START);
			while (start == prev)
				start = urand(MAX_START);
			prev = start;
			load_program(start);
			run_model(start);
			start_core(start);
			repeat (RUN_CYCLES) @(posedge clk);
			@(negedge clk);
			check_eq("o_pc_data in final loop", o_pc_data, (start + LOOP_IDX) * 4);
			quit_core();
			check_registers();
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

/* all.f */
logic/cpu_cfg_pkg.sv
logic/rv32i_isa_pkg.sv
logic/cpu_status.sv
logic/if_stage.sv
logic/id_stage.sv
logic/forwarding.sv
logic/ex_stage.sv
logic/cpu_top.sv
test/cpu_top_assert.sv
test/tb_cpu_top.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the result from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cpu_top -f all.f -o tb_sim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q 'Test failures found' sim.log && { echo "simulation FAILED"; exit 1; }
grep -q 'All tests passed!' sim.log && echo "simulation passed" || { echo "no result in sim.log"; exit 1; }
